//--- Bender.yml
package:
  name: ecc_mem

sources:
  - src/ecc_pkg.sv
  - src/ecc_46_top.sv
  - src/ecc_mem_array.sv
  - src/ecc_mem_ctrl.sv
  - src/ecc_regs.sv
  - src/ecc_mem_top.sv
  - target: simulation
    files:
      - verif/ecc_mem_tb.sv

//--- sim.f
src/ecc_pkg.sv
src/ecc_46_top.sv
src/ecc_mem_array.sv
src/ecc_mem_ctrl.sv
src/ecc_regs.sv
src/ecc_mem_top.sv
verif/ecc_mem_tb.sv

//--- src/ecc_46_top.sv
module ecc_46_top (
    input  logic [ecc_pkg::DATA_W-1:0] data_in,
    input  logic [ecc_pkg::PAR_W-1:0]  parity_in,
    input  logic                       bypass,
    output logic [ecc_pkg::DATA_W-1:0] data_out,
    output logic [ecc_pkg::PAR_W-1:0]  parity_out,
    output logic [ecc_pkg::DATA_W-1:0] mask,
    output ecc_pkg::ecc_flags_t        flags
);
    import ecc_pkg::*;

    logic [PAR_W-1:0] syndrome;
    logic [5:0]       pos;
    logic             hit;
    logic             syn_zero;
    logic             syn_chk;

    function automatic logic [PAR_W-1:0] ecc_encode(input logic [DATA_W-1:0] d);
        logic [PAR_W-1:0] p;
        p[0] = ^{d[0], d[1], d[3], d[4], d[6], d[8], d[10], d[11], d[13], d[15], d[17],
                 d[19], d[21], d[23], d[25], d[26], d[28], d[30], d[32], d[34], d[36],
                 d[38], d[40], d[42], d[44]};
        p[1] = ^{d[0], d[2], d[3], d[5], d[6], d[9], d[10], d[12], d[13], d[16], d[17],
                 d[20], d[21], d[24], d[25], d[27], d[28], d[31], d[32], d[35], d[36],
                 d[39], d[40], d[43], d[44]};
        p[2] = ^{d[45], d[40:37], d[32:29], d[25:22], d[17:14], d[10:7], d[3:1]};
        p[3] = ^{d[40:33], d[25:18], d[10:4]};
        p[4] = ^{d[45:41], d[25:11]};
        p[5] = ^d[45:26];
        p[6] = ^{d[0], d[1], d[2], d[4], d[5], d[7], d[10], d[11], d[12], d[14], d[17],
                 d[18], d[21], d[23], d[24], d[26], d[27], d[29], d[32], d[33], d[36],
                 d[38], d[39], d[41], d[44]};
        return p;
    endfunction

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // Syndrome to data bit position.
    always_comb begin
        hit = 1'b1;
        pos = '0;
        case (syndrome)
            7'b1000011: pos = 6'd0;
            7'b1000101: pos = 6'd1;
            7'b1000110: pos = 6'd2;
            7'b0000111: pos = 6'd3;
            7'b1001001: pos = 6'd4;
            7'b1001010: pos = 6'd5;
            7'b0001011: pos = 6'd6;
            7'b1001100: pos = 6'd7;
            7'b0001101: pos = 6'd8;
            7'b0001110: pos = 6'd9;
            7'b1001111: pos = 6'd10;
            7'b1010001: pos = 6'd11;
            7'b1010010: pos = 6'd12;
            7'b0010011: pos = 6'd13;
            7'b1010100: pos = 6'd14;
            7'b0010101: pos = 6'd15;
            7'b0010110: pos = 6'd16;
            7'b1010111: pos = 6'd17;
            7'b1011000: pos = 6'd18;
            7'b0011001: pos = 6'd19;
            7'b0011010: pos = 6'd20;
            7'b1011011: pos = 6'd21;
            7'b0011100: pos = 6'd22;
            7'b1011101: pos = 6'd23;
            7'b1011110: pos = 6'd24;
            7'b0011111: pos = 6'd25;
            7'b1100001: pos = 6'd26;
            7'b1100010: pos = 6'd27;
            7'b0100011: pos = 6'd28;
            7'b1100100: pos = 6'd29;
            7'b0100101: pos = 6'd30;
            7'b0100110: pos = 6'd31;
            7'b1100111: pos = 6'd32;
            7'b1101000: pos = 6'd33;
            7'b0101001: pos = 6'd34;
            7'b0101010: pos = 6'd35;
            7'b1101011: pos = 6'd36;
            7'b0101100: pos = 6'd37;
            7'b1101101: pos = 6'd38;
            7'b1101110: pos = 6'd39;
            7'b0101111: pos = 6'd40;
            7'b1110000: pos = 6'd41;
            7'b0110001: pos = 6'd42;
            7'b0110010: pos = 6'd43;
            7'b1110011: pos = 6'd44;
            7'b0110100: pos = 6'd45;
            default:    hit = 1'b0;
        endcase
    end

    // A weight-one syndrome points at a check bit.
    assign syn_zero = (syndrome == '0);
    assign syn_chk  = !syn_zero && ((syndrome & (syndrome - 1'b1)) == '0);

    assign mask       = hit ? (DATA_W'(1) << pos) : '0;
    assign data_out   = bypass ? data_in : (data_in ^ mask);
    assign flags.sbit = !bypass && (hit || syn_chk);
    assign flags.dbit = !bypass && !syn_zero && !hit && !syn_chk;

endmodule

//--- src/ecc_mem_array.sv
module ecc_mem_array (
    input  logic                       clk,
    input  logic                       we,
    input  logic [ecc_pkg::ADDR_W-1:0] waddr,
    input  ecc_pkg::codeword_u         wdata,
    input  logic                       re,
    input  logic [ecc_pkg::ADDR_W-1:0] raddr,
    output ecc_pkg::codeword_u         rdata
);
    import ecc_pkg::*;

    codeword_u mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read register holds its value between reads.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- src/ecc_mem_ctrl.sv
module ecc_mem_ctrl (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr_en,
    input  logic [ecc_pkg::ADDR_W-1:0] wr_addr,
    input  logic [ecc_pkg::DATA_W-1:0] wr_data,
    input  logic                       rd_en,
    input  logic [ecc_pkg::ADDR_W-1:0] rd_addr,
    input  logic                       bypass,
    input  logic [ecc_pkg::CW_W-1:0]   inj_mask,
    output logic                       inj_done,
    output ecc_pkg::rd_resp_t          rd_resp
);
    import ecc_pkg::*;

    logic [PAR_W-1:0]  enc_parity;
    codeword_u         cw_enc;
    codeword_u         cw_wr;
    codeword_u         cw_rd;
    logic              s1_valid;
    logic [ADDR_W-1:0] s1_addr;
    logic [DATA_W-1:0] dec_data;
    ecc_flags_t        dec_flags;
    logic              resp_valid;
    logic [ADDR_W-1:0] resp_addr;
    logic [DATA_W-1:0] resp_data;
    ecc_flags_t        resp_flags;

    ecc_46_top u_enc (
        .data_in    (wr_data),
        .parity_in  ('0),
        .bypass     (1'b0),
        .data_out   (),
        .parity_out (enc_parity),
        .mask       (),
        .flags      ()
    );

    // Fault injection flips codeword bits on the way into the array.
    always_comb begin
        cw_enc.fields.parity = enc_parity;
        cw_enc.fields.data   = wr_data;
        cw_wr.raw            = cw_enc.raw ^ inj_mask;
    end

    assign inj_done = wr_en;

    ecc_mem_array u_array (
        .clk   (clk),
        .we    (wr_en),
        .waddr (wr_addr),
        .wdata (cw_wr),
        .re    (rd_en),
        .raddr (rd_addr),
        .rdata (cw_rd)
    );

    ecc_46_top u_dec (
        .data_in    (cw_rd.fields.data),
        .parity_in  (cw_rd.fields.parity),
        .bypass     (bypass),
        .data_out   (dec_data),
        .parity_out (),
        .mask       (),
        .flags      (dec_flags)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            s1_valid   <= rd_en;
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s1_addr <= rd_addr;
        end
        if (s1_valid) begin
            resp_addr  <= s1_addr;
            resp_data  <= dec_data;
            resp_flags <= dec_flags;
        end
    end

    assign rd_resp = '{valid: resp_valid, addr: resp_addr, data: resp_data, flags: resp_flags};

endmodule

//--- src/ecc_mem_top.sv
module ecc_mem_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr_en,
    input  logic [ecc_pkg::ADDR_W-1:0] wr_addr,
    input  logic [ecc_pkg::DATA_W-1:0] wr_data,
    input  logic                       rd_en,
    input  logic [ecc_pkg::ADDR_W-1:0] rd_addr,
    output ecc_pkg::rd_resp_t          rd_resp,
    input  logic                       reg_wr,
    input  logic [ecc_pkg::REG_AW-1:0] reg_addr,
    input  logic [ecc_pkg::REG_DW-1:0] reg_wdata,
    output logic [ecc_pkg::REG_DW-1:0] reg_rdata
);
    import ecc_pkg::*;

    logic            bypass;
    logic [CW_W-1:0] inj_mask;
    logic            inj_done;

    ecc_mem_ctrl u_ctrl (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .bypass   (bypass),
        .inj_mask (inj_mask),
        .inj_done (inj_done),
        .rd_resp  (rd_resp)
    );

    // Every read response is also an error event for the counters.
    ecc_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .reg_wr    (reg_wr),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .inj_done  (inj_done),
        .err_evt   (rd_resp),
        .bypass    (bypass),
        .inj_mask  (inj_mask)
    );

endmodule

//--- src/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_W = 46;
    localparam int PAR_W  = 7;
    localparam int CW_W   = DATA_W + PAR_W;
    localparam int ADDR_W = 4;
    localparam int DEPTH  = 2 ** ADDR_W;
    localparam int CNT_W  = 8;
    localparam int REG_DW = 32;
    localparam int REG_AW = 3;

    // Register map.
    localparam logic [REG_AW-1:0] REG_CTRL     = 3'd0;
    localparam logic [REG_AW-1:0] REG_INJ_LO   = 3'd1;
    localparam logic [REG_AW-1:0] REG_INJ_HI   = 3'd2;
    localparam logic [REG_AW-1:0] REG_SBIT_CNT = 3'd3;
    localparam logic [REG_AW-1:0] REG_DBIT_CNT = 3'd4;
    localparam logic [REG_AW-1:0] REG_ERR_ADDR = 3'd5;
    localparam logic [REG_AW-1:0] REG_CLR      = 3'd6;

    typedef struct packed {
        logic [PAR_W-1:0]  parity;
        logic [DATA_W-1:0] data;
    } codeword_t;

    // Stored word, seen as fields by the codec and as raw bits by injection.
    typedef union packed {
        codeword_t         fields;
        logic [CW_W-1:0]   raw;
    } codeword_u;

    typedef struct packed {
        logic sbit;
        logic dbit;
    } ecc_flags_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        ecc_flags_t        flags;
    } rd_resp_t;

endpackage

//--- src/ecc_regs.sv
module ecc_regs (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       reg_wr,
    input  logic [ecc_pkg::REG_AW-1:0] reg_addr,
    input  logic [ecc_pkg::REG_DW-1:0] reg_wdata,
    output logic [ecc_pkg::REG_DW-1:0] reg_rdata,
    input  logic                       inj_done,
    input  ecc_pkg::rd_resp_t          err_evt,
    output logic                       bypass,
    output logic [ecc_pkg::CW_W-1:0]   inj_mask
);
    import ecc_pkg::*;

    logic [CNT_W-1:0]  sbit_cnt;
    logic [CNT_W-1:0]  dbit_cnt;
    logic [ADDR_W-1:0] err_addr;
    logic              cnt_clr;
    logic              sbit_evt;
    logic              dbit_evt;

    assign cnt_clr  = reg_wr && (reg_addr == REG_CLR);
    assign sbit_evt = err_evt.valid && err_evt.flags.sbit;
    assign dbit_evt = err_evt.valid && err_evt.flags.dbit;

    // A register write in the same cycle as a data write keeps the new mask.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bypass   <= 1'b0;
            inj_mask <= '0;
        end else begin
            if (inj_done) begin
                inj_mask <= '0;
            end
            if (reg_wr && (reg_addr == REG_CTRL)) begin
                bypass <= reg_wdata[0];
            end
            if (reg_wr && (reg_addr == REG_INJ_LO)) begin
                inj_mask[REG_DW-1:0] <= reg_wdata;
            end
            if (reg_wr && (reg_addr == REG_INJ_HI)) begin
                inj_mask[CW_W-1:REG_DW] <= reg_wdata[CW_W-REG_DW-1:0];
            end
        end
    end

    // Counters stick at all ones.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sbit_cnt <= '0;
            dbit_cnt <= '0;
            err_addr <= '0;
        end else begin
            if (cnt_clr) begin
                sbit_cnt <= '0;
            end else if (sbit_evt && (sbit_cnt != '1)) begin
                sbit_cnt <= sbit_cnt + 1'b1;
            end
            if (cnt_clr) begin
                dbit_cnt <= '0;
            end else if (dbit_evt && (dbit_cnt != '1)) begin
                dbit_cnt <= dbit_cnt + 1'b1;
            end
            if (sbit_evt || dbit_evt) begin
                err_addr <= err_evt.addr;
            end
        end
    end

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            REG_CTRL:     reg_rdata[0] = bypass;
            REG_INJ_LO:   reg_rdata = inj_mask[REG_DW-1:0];
            REG_INJ_HI:   reg_rdata[CW_W-REG_DW-1:0] = inj_mask[CW_W-1:REG_DW];
            REG_SBIT_CNT: reg_rdata[CNT_W-1:0] = sbit_cnt;
            REG_DBIT_CNT: reg_rdata[CNT_W-1:0] = dbit_cnt;
            REG_ERR_ADDR: reg_rdata[ADDR_W-1:0] = err_addr;
            default:      reg_rdata = '0;
        endcase
    end

endmodule

//--- verif/ecc_mem_tb.sv
module ecc_mem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ecc_pkg::*;

    logic              clk;
    logic              arst_n;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    rd_resp_t          rd_resp;
    logic              reg_wr;
    logic [REG_AW-1:0] reg_addr;
    logic [REG_DW-1:0] reg_wdata;
    logic [REG_DW-1:0] reg_rdata;

    logic [DATA_W-1:0] ref_data [DEPTH];
    logic [CW_W-1:0]   ref_flip [DEPTH];
    rd_resp_t          exp_q [$];
    rd_resp_t          exp_s1;
    rd_resp_t          exp_s2;
    logic              bypass_on = 1'b0;
    logic [CNT_W-1:0]  sbit_model = '0;
    logic [CNT_W-1:0]  dbit_model = '0;
    logic [ADDR_W-1:0] err_addr_model = '0;
    logic              chk_en;
    logic [REG_DW-1:0] chk_exp;
    string             test_name = "reset";
    int                err_cnt = 0;
    int                resp_cnt = 0;
    int                rd_cnt = 0;

    ecc_mem_top u_ecc_mem_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Expected responses follow the DUT pipeline, two edges behind rd_en.
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_s1 <= '0;
            exp_s2 <= '0;
        end else begin
            if (rd_en) begin
                exp_s1 <= exp_q.pop_front();
            end else begin
                exp_s1 <= '0;
            end
            exp_s2 <= exp_s1;
            if (rd_resp.valid) begin
                resp_cnt <= resp_cnt + 1;
            end
        end
    end

    latency_check: assert property (@(posedge clk) disable iff (!arst_n)
        rd_en |-> ##2 rd_resp.valid)
    else begin
        err_cnt++;
        $display("read response did not arrive two cycles after rd_en (%s)", test_name);
    end

    resp_check: assert property (@(posedge clk) disable iff (!arst_n)
        rd_resp.valid |-> rd_resp == exp_s2)
    else begin
        err_cnt++;
        $display("mismatch %s: expected %h, actual %h", test_name, $sampled(exp_s2),
                 $sampled(rd_resp));
    end

    reg_check: assert property (@(posedge clk) disable iff (!arst_n)
        chk_en |-> reg_rdata == chk_exp)
    else begin
        err_cnt++;
        $display("mismatch %s: expected %h, actual %h", test_name, $sampled(chk_exp),
                 $sampled(reg_rdata));
    end

    function automatic logic [DATA_W-1:0] rand_data();
        return DATA_W'({$urandom(), $urandom()});
    endfunction

    // One flipped bit is corrected or reported, two flipped bits are only flagged.
    function automatic rd_resp_t expect_read(input logic [ADDR_W-1:0] a);
        rd_resp_t          r;
        logic [DATA_W-1:0] dflip;
        int                n;
        dflip = ref_flip[a][DATA_W-1:0];
        n = $countones(ref_flip[a]);
        r = '{valid: 1'b1, addr: a, data: ref_data[a], flags: '0};
        if (bypass_on) begin
            r.data = ref_data[a] ^ dflip;
        end else if (n == 1) begin
            r.flags.sbit = 1'b1;
        end else if (n == 2) begin
            r.data = ref_data[a] ^ dflip;
            r.flags.dbit = 1'b1;
        end
        return r;
    endfunction

    task automatic reg_write(input logic [REG_AW-1:0] a, input logic [REG_DW-1:0] d);
        @(posedge clk);
        reg_wr <= 1'b1;
        reg_addr <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic check_reg(input logic [REG_AW-1:0] a, input logic [REG_DW-1:0] e);
        @(posedge clk);
        reg_addr <= a;
        chk_exp <= e;
        chk_en <= 1'b1;
        @(posedge clk);
        chk_en <= 1'b0;
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                              input logic [CW_W-1:0] flip);
        if (flip != '0) begin
            reg_write(REG_INJ_LO, flip[REG_DW-1:0]);
            reg_write(REG_INJ_HI, REG_DW'(flip[CW_W-1:REG_DW]));
        end
        @(posedge clk);
        wr_en <= 1'b1;
        wr_addr <= a;
        wr_data <= d;
        @(posedge clk);
        wr_en <= 1'b0;
        ref_data[a] = d;
        ref_flip[a] = flip;
    endtask

    task automatic start_read(input logic [ADDR_W-1:0] a);
        rd_resp_t r;
        r = expect_read(a);
        exp_q.push_back(r);
        rd_cnt++;
        if (r.flags.sbit && sbit_model != '1) sbit_model++;
        if (r.flags.dbit && dbit_model != '1) dbit_model++;
        if (r.flags != '0) err_addr_model = a;
        rd_en <= 1'b1;
        rd_addr <= a;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (resp_cnt < rd_cnt && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (resp_cnt < rd_cnt) begin
            $display("timeout: read responses did not drain in %s", test_name);
            $display("errors: %0d, responses checked: %0d", err_cnt, resp_cnt);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic read_pair(input logic [ADDR_W-1:0] a, input logic [ADDR_W-1:0] b);
        @(posedge clk);
        start_read(a);
        @(posedge clk);
        start_read(b);
        @(posedge clk);
        rd_en <= 1'b0;
        wait_drain();
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        start_read(a);
        @(posedge clk);
        rd_en <= 1'b0;
        wait_drain();
    endtask

    initial begin
        int b0;
        int b1;
        void'($urandom(76));
        arst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        chk_en = 1'b0;
        chk_exp = '0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        test_name = "clean";
        for (int i = 0; i < 4; i++) begin
            write_word(ADDR_W'(i), rand_data(), '0);
            read_word(ADDR_W'(i));
        end

        test_name = "single_data";
        write_word(4'd5, rand_data(), CW_W'(1) << $urandom_range(DATA_W - 1, 0));
        read_word(4'd5);
        check_reg(REG_SBIT_CNT, REG_DW'(sbit_model));
        check_reg(REG_ERR_ADDR, REG_DW'(err_addr_model));

        test_name = "single_check";
        write_word(4'd7, rand_data(), CW_W'(1) << (DATA_W + $urandom_range(PAR_W - 1, 0)));
        read_word(4'd7);
        check_reg(REG_SBIT_CNT, REG_DW'(sbit_model));

        test_name = "double";
        b0 = $urandom_range(DATA_W - 1, 0);
        b1 = (b0 + 1 + $urandom_range(DATA_W - 2, 0)) % DATA_W;
        write_word(4'd9, rand_data(), (CW_W'(1) << b0) | (CW_W'(1) << b1));
        read_word(4'd9);
        check_reg(REG_DBIT_CNT, REG_DW'(dbit_model));
        check_reg(REG_ERR_ADDR, REG_DW'(err_addr_model));

        test_name = "bypass";
        reg_write(REG_CTRL, 32'd1);
        bypass_on = 1'b1;
        write_word(4'd11, rand_data(), CW_W'(1) << $urandom_range(DATA_W - 1, 0));
        read_word(4'd11);
        read_word(4'd9);
        check_reg(REG_SBIT_CNT, REG_DW'(sbit_model));
        check_reg(REG_DBIT_CNT, REG_DW'(dbit_model));
        reg_write(REG_CTRL, 32'd0);
        bypass_on = 1'b0;

        test_name = "one_shot";
        write_word(4'd12, rand_data(), CW_W'(1) << 3);
        write_word(4'd13, rand_data(), '0);
        check_reg(REG_INJ_LO, '0);
        read_pair(4'd13, 4'd12);
        read_pair(4'd5, 4'd2);

        test_name = "clear";
        reg_write(REG_CLR, '0);
        sbit_model = '0;
        dbit_model = '0;
        check_reg(REG_SBIT_CNT, '0);
        check_reg(REG_DBIT_CNT, '0);

        repeat (2) @(posedge clk);
        $display("errors: %0d, responses checked: %0d", err_cnt, resp_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
